// ==== vlog.f ====
common/gamePkg.sv
datapath/seqMemory.sv
datapath/gameDatapath.sv
control/gameControl.sv
rtl/hexDisplay.sv
rtl/memoryGame.sv
bench/memoryGameTb.sv

// ==== Bender.yml ====
package:
  name: memory_game

sources:
  - common/gamePkg.sv
  - datapath/seqMemory.sv
  - datapath/gameDatapath.sv
  - control/gameControl.sv
  - rtl/hexDisplay.sv
  - rtl/memoryGame.sv
  - target: test
    files:
      - bench/memoryGameTb.sv

// ==== bench/memoryGameTb.sv ====
module memoryGameTb;

    localparam int ShowCycles = 4;

    logic               clock = 1'b0;
    logic               rst;
    logic               iniciar;
    logic               nivelJogadas;
    logic               nivelTempo;
    gamePkg::move_t     chaves;
    logic               acertou;
    logic               errou;
    logic               pronto;
    logic               vezJogador;
    logic               timeout;
    gamePkg::move_t     leds;
    logic               dbIgual;
    logic               dbNivelJogadas;
    logic               dbNivelTempo;
    logic               dbTemJogada;
    gamePkg::segments_t dbContagem;
    gamePkg::segments_t dbMemoria;
    gamePkg::segments_t dbEstado;

    // Player's own copy of the sequence
    gamePkg::move_t moveTable [16] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h4, 4'h2, 4'h1, 4'h1,
                                       4'h2, 4'h2, 4'h4, 4'h4, 4'h8, 4'h8, 4'h1, 4'h4};

    logic [31:0] lfsr = 32'h523d9715;
    string       testName;
    int          testErrors = 0;
    int          testCount = 0;
    int          failedTests = 0;

    memoryGame #(
        .ShowCycles   (ShowCycles),
        .TimeoutShort (40),
        .TimeoutLong  (120)
    ) u_dut (.*);

    always #4 clock = ~clock;

    function automatic int unsigned randBits(int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    // Segments a to g in bits 0 to 6
    function automatic gamePkg::segments_t segmentsOf(logic [3:0] digit);
        case (digit)
            4'h0:    return 7'b0111111;
            4'h1:    return 7'b0000110;
            4'h2:    return 7'b1011011;
            4'h3:    return 7'b1001111;
            4'h4:    return 7'b1100110;
            4'h5:    return 7'b1101101;
            4'h6:    return 7'b1111101;
            4'h7:    return 7'b0000111;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1101111;
            4'hA:    return 7'b1110111;
            4'hB:    return 7'b1111100;
            4'hC:    return 7'b0111001;
            4'hD:    return 7'b1011110;
            4'hE:    return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic gamePkg::move_t wrongMove(gamePkg::move_t right);
        gamePkg::move_t pattern;
        pattern = gamePkg::move_t'(randBits(4));
        if (pattern == '0 || pattern == right) begin
            pattern = right ^ 4'b0011;
        end
        return pattern;
    endfunction

    task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0h, actual %0h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic abortRun(string why);
        $display("Test %s stopped: %s", testName, why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic beginTest(string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testCount++;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("Test %s finished with %0d errors", testName, testErrors);
    endtask

    task automatic startGame(logic rounds16, logic timeLong);
        nivelJogadas = rounds16;
        nivelTempo   = timeLong;
        iniciar      = 1'b1;
        @(negedge clock);
        iniciar = 1'b0;
    endtask

    // Records the shown moves until the player's turn or the end of the game
    task automatic watchShow(int r, output bit ended);
        gamePkg::move_t shown [$];
        gamePkg::move_t prevLeds;
        int             litLen;
        ended    = 1'b0;
        prevLeds = '0;
        litLen   = 0;
        for (int i = 0; i < (r + 1) * 2 * ShowCycles + 16; i++) begin
            @(negedge clock);
            if (pronto) begin
                ended = 1'b1;
                return;
            end
            if (vezJogador && !dbTemJogada) begin
                compare("moves shown", r + 1, shown.size());
                foreach (shown[k]) begin
                    compare($sformatf("shown move %0d", k), moveTable[k], shown[k]);
                end
                return;
            end
            if (leds != '0) begin
                if (prevLeds == '0) begin
                    compare("dbMemoria", segmentsOf(moveTable[shown.size()]), dbMemoria);
                    compare("dbContagem", segmentsOf(gamePkg::addr_t'(shown.size())), dbContagem);
                    shown.push_back(leds);
                end
                litLen++;
            end else if (prevLeds != '0) begin
                compare("lit cycles", ShowCycles, litLen);
                litLen = 0;
            end
            prevLeds = leds;
        end
        abortRun("the player's turn never came");
    endtask

    task automatic waitTurn();
        for (int i = 0; i < 8; i++) begin
            @(negedge clock);
            if (vezJogador && !dbTemJogada) begin
                return;
            end
        end
        abortRun("the game did not return to the player's turn");
    endtask

    task automatic pressMove(gamePkg::move_t pattern, int gap);
        repeat (gap) @(negedge clock);
        chaves = pattern;
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            if (dbTemJogada) begin
                chaves = '0;
                return;
            end
        end
        abortRun("a switch press was not taken as a move");
    endtask

    task automatic waitEnd(int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge clock);
            if (pronto) begin
                return;
            end
        end
        abortRun("the game did not end in time");
    endtask

    // Plays rounds until the game ends, one wrong move at failRound and failPos
    task automatic playGame(int failRound, int failPos, int firstGap, bit toggle,
                            output int rounds);
        bit             ended;
        gamePkg::move_t pattern;
        int             gap;
        rounds = 0;
        ended  = 1'b0;
        while (!ended && rounds < 20) begin
            watchShow(rounds, ended);
            if (!ended) begin
                if (toggle) begin
                    nivelJogadas = ~nivelJogadas;
                    nivelTempo   = ~nivelTempo;
                    compare("dbNivelJogadas", 1, dbNivelJogadas);
                end
                for (int p = 0; p <= rounds; p++) begin
                    if (p > 0) begin
                        waitTurn();
                    end
                    gap     = (rounds == 0 && p == 0 && firstGap >= 0) ? firstGap : randBits(3);
                    pattern = moveTable[p];
                    if (rounds == failRound && p == failPos) begin
                        pattern = wrongMove(pattern);
                    end
                    pressMove(pattern, gap);
                    if (pattern != moveTable[p]) begin
                        break;
                    end
                end
                rounds++;
            end
        end
    endtask

    task automatic checkEnd(logic won, logic lost, logic late);
        compare("pronto", 1, pronto);
        compare("acertou", won, acertou);
        compare("errou", lost, errou);
        compare("timeout", late, timeout);
    endtask

    initial begin
        int rounds;
        int failRound;
        int failPos;
        bit ended;
        rst          = 1'b1;
        iniciar      = 1'b0;
        chaves       = '0;
        nivelJogadas = 1'b0;
        nivelTempo   = 1'b0;
        repeat (2) @(negedge clock);
        rst = 1'b0;

        beginTest("reset");
        compare("end outputs", 0, {acertou, errou, pronto, vezJogador, timeout});
        compare("leds", 0, leds);
        compare("dbEstado", segmentsOf(4'h0), dbEstado);
        endTest();

        beginTest("win8");
        startGame(1'b0, 1'b0);
        playGame(-1, 0, -1, 1'b0, rounds);
        compare("rounds", 8, rounds);
        checkEnd(1'b1, 1'b0, 1'b0);
        endTest();

        beginTest("wrongMove");
        failRound = randBits(3);
        failPos   = randBits(3) % (failRound + 1);
        startGame(1'b0, 1'b0);
        playGame(failRound, failPos, -1, 1'b0, rounds);
        compare("rounds", failRound + 1, rounds);
        checkEnd(1'b0, 1'b1, 1'b0);
        endTest();

        beginTest("timeLimit");
        startGame(1'b0, 1'b0);
        watchShow(0, ended);
        waitEnd(120);
        checkEnd(1'b0, 1'b0, 1'b1);
        // Long limit lets a slow first answer through
        startGame(1'b0, 1'b1);
        playGame(-1, 0, 60, 1'b0, rounds);
        compare("dbNivelTempo", 1, dbNivelTempo);
        compare("rounds", 8, rounds);
        checkEnd(1'b1, 1'b0, 1'b0);
        endTest();

        beginTest("win16");
        startGame(1'b1, 1'b0);
        playGame(-1, 0, -1, 1'b1, rounds);
        compare("rounds", 16, rounds);
        compare("dbNivelJogadas", 1, dbNivelJogadas);
        checkEnd(1'b1, 1'b0, 1'b0);
        endTest();

        beginTest("displays");
        failRound = randBits(2);
        failPos   = randBits(2) % (failRound + 1);
        startGame(1'b0, 1'b0);
        playGame(failRound, failPos, -1, 1'b0, rounds);
        checkEnd(1'b0, 1'b1, 1'b0);
        compare("dbIgual", 0, dbIgual);
        endTest();

        $display("%0d of %0d tests passed", testCount - failedTests, testCount);
        if (failedTests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rtl/memoryGame.sv ====
module memoryGame #(
    parameter int unsigned ShowCycles   = 4,
    parameter int unsigned TimeoutShort = 40,
    parameter int unsigned TimeoutLong  = 120
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               iniciar,
    input  gamePkg::move_t     chaves,
    input  logic               nivelJogadas,
    input  logic               nivelTempo,

    output logic               acertou,
    output logic               errou,
    output logic               pronto,
    output logic               vezJogador,
    output logic               timeout,
    output gamePkg::move_t     leds,

    output logic               dbIgual,
    output logic               dbNivelJogadas,
    output logic               dbNivelTempo,
    output logic               dbTemJogada,
    output gamePkg::segments_t dbContagem,
    output gamePkg::segments_t dbMemoria,
    output gamePkg::segments_t dbEstado
);

    gamePkg::dpCtrl_t   ctrl;
    gamePkg::dpStatus_t status;
    gamePkg::hexDigit_t addrDigit;
    gamePkg::hexDigit_t memDigit;
    gamePkg::hexDigit_t stateDigit;

    gameDatapath #(
        .ShowCycles   (ShowCycles),
        .TimeoutShort (TimeoutShort),
        .TimeoutLong  (TimeoutLong)
    ) u_datapath (
        .clock        (clock),
        .rst          (rst),
        .chaves       (chaves),
        .nivelJogadas (nivelJogadas),
        .nivelTempo   (nivelTempo),
        .ctrl         (ctrl),
        .status       (status),
        .leds         (leds),
        .addrDigit    (addrDigit),
        .memDigit     (memDigit)
    );

    gameControl u_control (
        .clock      (clock),
        .rst        (rst),
        .iniciar    (iniciar),
        .status     (status),
        .ctrl       (ctrl),
        .acertou    (acertou),
        .errou      (errou),
        .pronto     (pronto),
        .vezJogador (vezJogador),
        .timeout    (timeout),
        .stateDigit (stateDigit)
    );

    // Debug bits straight from the datapath status
    assign dbIgual        = status.moveCorrect;
    assign dbNivelJogadas = status.levelRounds;
    assign dbNivelTempo   = status.levelTime;
    assign dbTemJogada    = status.movePending;

    // Address counter
    hexDisplay u_hexContagem (
        .digit    (addrDigit),
        .segments (dbContagem)
    );

    // Table entry at the current address
    hexDisplay u_hexMemoria (
        .digit    (memDigit),
        .segments (dbMemoria)
    );

    hexDisplay u_hexEstado (
        .digit    (stateDigit),
        .segments (dbEstado)
    );

endmodule

// ==== rtl/hexDisplay.sv ====
module hexDisplay (
    input  gamePkg::hexDigit_t digit,
    output gamePkg::segments_t segments
);

    // Bit order g f e d c b a
    always_comb begin
        case (digit)
            4'h0:    segments = 7'b0111111;
            4'h1:    segments = 7'b0000110;
            4'h2:    segments = 7'b1011011;
            4'h3:    segments = 7'b1001111;
            4'h4:    segments = 7'b1100110;
            4'h5:    segments = 7'b1101101;
            4'h6:    segments = 7'b1111101;
            4'h7:    segments = 7'b0000111;
            4'h8:    segments = 7'b1111111;
            4'h9:    segments = 7'b1101111;
            4'hA:    segments = 7'b1110111;
            4'hB:    segments = 7'b1111100;
            4'hC:    segments = 7'b0111001;
            4'hD:    segments = 7'b1011110;
            4'hE:    segments = 7'b1111001;
            default: segments = 7'b1110001;
        endcase
    end

endmodule

// ==== control/gameControl.sv ====
module gameControl (
    input  logic                clock,
    input  logic                rst,
    input  logic                iniciar,
    input  gamePkg::dpStatus_t  status,
    output gamePkg::dpCtrl_t    ctrl,
    output logic                acertou,
    output logic                errou,
    output logic                pronto,
    output logic                vezJogador,
    output logic                timeout,
    output gamePkg::hexDigit_t  stateDigit
);

    gamePkg::gameStateE state;
    gamePkg::gameStateE stateNext;

    always_comb begin
        stateNext = state;
        ctrl      = '0;

        unique case (state)
            gamePkg::Idle,
            gamePkg::Won,
            gamePkg::Lost,
            gamePkg::TimedOut: begin
                if (iniciar) begin
                    stateNext = gamePkg::Prep;
                end
            end

            gamePkg::Prep: begin
                ctrl.captureLevels = 1'b1;
                ctrl.clearRound    = 1'b1;
                ctrl.clearAddr     = 1'b1;
                ctrl.clearShow     = 1'b1;
                ctrl.clearTimer    = 1'b1;
                stateNext          = gamePkg::ShowOn;
            end

            // Move lit for ShowCycles cycles
            gamePkg::ShowOn: begin
                ctrl.showLed = 1'b1;
                ctrl.runShow = 1'b1;
                if (status.showDone) begin
                    ctrl.clearShow = 1'b1;
                    stateNext      = gamePkg::ShowOff;
                end
            end

            // Dark gap, then next move or the player's turn
            gamePkg::ShowOff: begin
                ctrl.runShow = 1'b1;
                if (status.showDone) begin
                    ctrl.clearShow = 1'b1;
                    if (status.addrAtRound) begin
                        ctrl.clearAddr  = 1'b1;
                        ctrl.clearTimer = 1'b1;
                        stateNext       = gamePkg::WaitMove;
                    end else begin
                        ctrl.incAddr = 1'b1;
                        stateNext    = gamePkg::ShowOn;
                    end
                end
            end

            gamePkg::WaitMove: begin
                ctrl.enableMove = 1'b1;
                ctrl.runTimer   = 1'b1;
                // A move that lands with the limit still counts
                if (status.movePending) begin
                    stateNext = gamePkg::CheckMove;
                end else if (status.timerDone) begin
                    stateNext = gamePkg::TimedOut;
                end
            end

            gamePkg::CheckMove: begin
                if (!status.moveCorrect) begin
                    stateNext = gamePkg::Lost;
                end else if (!status.addrAtRound) begin
                    ctrl.incAddr    = 1'b1;
                    ctrl.clearTimer = 1'b1;
                    stateNext       = gamePkg::WaitMove;
                end else if (status.lastRound) begin
                    stateNext = gamePkg::Won;
                end else begin
                    stateNext = gamePkg::NextRound;
                end
            end

            gamePkg::NextRound: begin
                ctrl.incRound  = 1'b1;
                ctrl.clearAddr = 1'b1;
                ctrl.clearShow = 1'b1;
                stateNext      = gamePkg::ShowOn;
            end

            default: begin
                stateNext = gamePkg::Idle;
            end
        endcase
    end

    // Outputs follow the next state so they line up with the state register
    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= gamePkg::Idle;
            acertou    <= 1'b0;
            errou      <= 1'b0;
            timeout    <= 1'b0;
            pronto     <= 1'b0;
            vezJogador <= 1'b0;
        end else begin
            state      <= stateNext;
            acertou    <= (stateNext == gamePkg::Won);
            errou      <= (stateNext == gamePkg::Lost);
            timeout    <= (stateNext == gamePkg::TimedOut);
            pronto     <= (stateNext == gamePkg::Won) || (stateNext == gamePkg::Lost)
                       || (stateNext == gamePkg::TimedOut);
            vezJogador <= (stateNext == gamePkg::WaitMove)
                       || (stateNext == gamePkg::CheckMove);
        end
    end

    assign stateDigit = gamePkg::hexDigit_t'(state);

    // One outcome per game
    assert property (@(posedge clock) disable iff (rst)
        $onehot0({acertou, errou, timeout}))
    else $error("gameControl: more than one end-of-game output high");

endmodule

// ==== datapath/gameDatapath.sv ====
module gameDatapath #(
    parameter int unsigned ShowCycles   = 4,
    parameter int unsigned TimeoutShort = 40,
    parameter int unsigned TimeoutLong  = 120
) (
    input  logic                clock,
    input  logic                rst,
    input  gamePkg::move_t      chaves,
    input  logic                nivelJogadas,
    input  logic                nivelTempo,
    input  gamePkg::dpCtrl_t    ctrl,
    output gamePkg::dpStatus_t  status,
    output gamePkg::move_t      leds,
    output gamePkg::hexDigit_t  addrDigit,
    output gamePkg::hexDigit_t  memDigit
);

    gamePkg::addr_t   roundCnt;
    gamePkg::addr_t   addrCnt;
    gamePkg::cycles_t showCnt;
    gamePkg::cycles_t timerCnt;
    gamePkg::cycles_t timerLimit;
    gamePkg::move_t   memMove;
    gamePkg::move_t   prevChaves;
    gamePkg::move_t   storedMove;
    logic             levelRounds;
    logic             levelTime;
    logic             movePending;
    logic             moveAccept;
    logic             showDone;
    logic             timerDone;

    seqMemory u_seqMemory (
        .addr (addrCnt),
        .move (memMove)
    );

    // Levels are frozen for the whole game
    always_ff @(posedge clock) begin
        if (rst) begin
            levelRounds <= 1'b0;
            levelTime   <= 1'b0;
        end else if (ctrl.captureLevels) begin
            levelRounds <= nivelJogadas;
            levelTime   <= nivelTempo;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || ctrl.clearRound) begin
            roundCnt <= '0;
        end else if (ctrl.incRound) begin
            roundCnt <= roundCnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || ctrl.clearAddr) begin
            addrCnt <= '0;
        end else if (ctrl.incAddr) begin
            addrCnt <= addrCnt + 1'b1;
        end
    end

    // Show timer paces both the lit and the dark half of a shown move
    always_ff @(posedge clock) begin
        if (rst || ctrl.clearShow) begin
            showCnt <= '0;
        end else if (ctrl.runShow) begin
            showCnt <= showCnt + 1'b1;
        end
    end

    assign showDone = (showCnt == gamePkg::cycles_t'(ShowCycles - 1));

    // Time limit, holds once reached
    assign timerLimit = levelTime ? gamePkg::cycles_t'(TimeoutLong)
                                  : gamePkg::cycles_t'(TimeoutShort);
    assign timerDone  = (timerCnt == timerLimit);

    always_ff @(posedge clock) begin
        if (rst || ctrl.clearTimer) begin
            timerCnt <= '0;
        end else if (ctrl.runTimer && !timerDone) begin
            timerCnt <= timerCnt + 1'b1;
        end
    end

    // Press after release of the switches
    assign moveAccept = ctrl.enableMove && (chaves != '0) && (prevChaves == '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            prevChaves <= '0;
            storedMove <= '0;
        end else begin
            prevChaves <= chaves;
            if (moveAccept) begin
                storedMove <= chaves;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || ctrl.clearTimer) begin
            movePending <= 1'b0;
        end else if (moveAccept) begin
            movePending <= 1'b1;
        end
    end

    always_comb begin
        if (ctrl.showLed) begin
            leds = memMove;
        end else if (ctrl.enableMove) begin
            leds = storedMove;
        end else begin
            leds = '0;
        end
    end

    always_comb begin
        status.showDone    = showDone;
        status.addrAtRound = (addrCnt == roundCnt);
        status.lastRound   = (roundCnt == (levelRounds ? 4'd15 : 4'd7));
        status.timerDone   = timerDone;
        status.movePending = movePending;
        // Exact match only, several bits set is a wrong move
        status.moveCorrect = (storedMove == memMove);
        status.levelRounds = levelRounds;
        status.levelTime   = levelTime;
    end

    assign addrDigit = gamePkg::hexDigit_t'(addrCnt);
    assign memDigit  = gamePkg::hexDigit_t'(memMove);

    // Switch activity outside the player's turn must leave no trace
    assert property (@(posedge clock) disable iff (rst)
        !ctrl.enableMove |=> $stable(storedMove) && !$rose(movePending))
    else $error("gameDatapath: move stored while enableMove was low");

endmodule

// ==== datapath/seqMemory.sv ====
module seqMemory (
    input  gamePkg::addr_t addr,
    output gamePkg::move_t move
);

    // Fixed sequence, every entry lights exactly one LED
    always_comb begin
        case (addr)
            4'd0:    move = 4'b0001;
            4'd1:    move = 4'b0010;
            4'd2:    move = 4'b0100;
            4'd3:    move = 4'b1000;
            4'd4:    move = 4'b0100;
            4'd5:    move = 4'b0010;
            4'd6:    move = 4'b0001;
            4'd7:    move = 4'b0001;
            4'd8:    move = 4'b0010;
            4'd9:    move = 4'b0010;
            4'd10:   move = 4'b0100;
            4'd11:   move = 4'b0100;
            4'd12:   move = 4'b1000;
            4'd13:   move = 4'b1000;
            4'd14:   move = 4'b0001;
            default: move = 4'b0100;
        endcase
    end

    // Every address decodes to a single LED
    always_comb begin
        assert #0 ($onehot(move))
        else $error("seqMemory: entry at address %0d is not one-hot", addr);
    end

endmodule

// ==== common/gamePkg.sv ====
package gamePkg;

    // Switch and LED move pattern, one-hot when valid
    typedef logic [3:0] move_t;

    // Table address or round number
    typedef logic [3:0] addr_t;

    // Timer count
    typedef logic [15:0] cycles_t;

    // Value fed to a seven-segment decoder
    typedef logic [3:0] hexDigit_t;

    // Active high segments, bit 0 is a and bit 6 is g
    typedef logic [6:0] segments_t;

    // State code doubles as the debug digit on the display
    typedef enum logic [3:0] {
        Idle      = 4'd0,
        Prep      = 4'd1,
        ShowOn    = 4'd2,
        ShowOff   = 4'd3,
        WaitMove  = 4'd4,
        CheckMove = 4'd5,
        NextRound = 4'd6,
        Won       = 4'd10,
        Lost      = 4'd14,
        TimedOut  = 4'd15
    } gameStateE;

    // Strobes from the control unit, each acts in the cycle it is high
    typedef struct packed {
        logic captureLevels;
        logic clearRound;
        logic incRound;
        logic clearAddr;
        logic incAddr;
        logic clearShow;
        logic runShow;
        logic clearTimer;
        logic runTimer;
        logic enableMove;
        logic showLed;
    } dpCtrl_t;

    // Conditions returned by the datapath
    typedef struct packed {
        logic showDone;
        logic addrAtRound;
        logic lastRound;
        logic timerDone;
        logic movePending;
        logic moveCorrect;
        logic levelRounds;
        logic levelTime;
    } dpStatus_t;

endpackage
